// ==== compile.f ====
fp_add_pkg.sv
fp_add_unpack.sv
fp_add_align.sv
fp_add_sum.sv
fp_add_normalize.sv
fp_adder.sv
tb_clk_gen.sv
fp_adder_props.sv
fp_adder_tb.sv

// ==== Bender.yml ====
package:
  name: fp_adder

sources:
  - files:
      - fp_add_pkg.sv
      - fp_add_unpack.sv
      - fp_add_align.sv
      - fp_add_sum.sv
      - fp_add_normalize.sv
      - fp_adder.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - fp_adder_props.sv
      - fp_adder_tb.sv

// ==== fp_adder_tb.sv ====
/*
 * Testbench for the pipelined float adder
 * Streams a table of operand pairs through the DUT, first with the clock
 * enable held high, then with a pseudo-random stall pattern. Every result
 * is checked in order against the table, together with its latency in
 * enabled edges.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_adder_tb;
    import fp_add_pkg::*;

    // One table row; flags are {invalid, overflow, underflow, inexact}
    typedef struct packed {
        float32_t    a;
        float32_t    b;
        fp_op_e      op;
        float32_t    result;
        round_bits_t rb;
        logic [3:0]  flags;
    } vector_t;

    logic        clk;
    logic        rst_n;
    logic        clk_en;
    logic        in_valid;
    float32_t    addend_a;
    float32_t    addend_b;
    fp_op_e      operation;
    float32_t    result;
    logic        out_valid;
    logic        invalid_op;
    logic        inexact;
    logic        overflow;
    logic        underflow;
    round_bits_t round_bits;

    vector_t     table_q[$];
    int unsigned taken_q[$];
    int unsigned en_edges  = 0;
    int unsigned errors    = 0;
    logic [31:0] rng_state = 32'd3;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fp_adder u_fp_adder (
        .clk_i               (clk),
        .rst_n_i             (rst_n),
        .clk_en_i            (clk_en),
        .data_valid_i        (in_valid),
        .addend_a_i          (addend_a),
        .addend_b_i          (addend_b),
        .operation_i         (operation),
        .result_o            (result),
        .data_valid_o        (out_valid),
        .invalid_operation_o (invalid_op),
        .inexact_o           (inexact),
        .overflow_o          (overflow),
        .underflow_o         (underflow),
        .round_bits_o        (round_bits)
    );

    // Running count of enabled edges, used as the pipeline time base
    always @(posedge clk) begin
        if (clk_en) begin
            en_edges <= en_edges + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h",
                                     name, got, expected));
        end
    endtask

    task automatic add_row(input float32_t a, input float32_t b, input fp_op_e op,
                           input float32_t res, input round_bits_t rb,
                           input logic [3:0] flags);
        vector_t v;
        v = '{a: a, b: b, op: op, result: res, rb: rb, flags: flags};
        table_q.push_back(v);
    endtask

    // Expected values follow the unrounded normalization rules
    task automatic load_table();
        // 1.0 + 2.0 and 1.5 + 1.5, the second one through the carry path
        add_row(32'h3F80_0000, 32'h4000_0000, FP_ADD, 32'h4040_0000, 3'b000, 4'b0000);
        add_row(32'h3FC0_0000, 32'h3FC0_0000, FP_ADD, 32'h4040_0000, 3'b000, 4'b0000);
        // 3.0 - 2.5 shifts left by two, 5.0 - 5.0 cancels to +0
        add_row(32'h4040_0000, 32'h4020_0000, FP_SUB, 32'h3F00_0000, 3'b000, 4'b0000);
        add_row(32'h40A0_0000, 32'h40A0_0000, FP_SUB, 32'h0000_0000, 3'b000, 4'b0010);
        // Cancelling infinities and NaN on either side
        add_row(32'h7F80_0000, 32'h7F80_0000, FP_SUB, 32'h7FC0_0000, 3'b000, 4'b1000);
        add_row(32'h7FC0_0001, 32'h3F80_0000, FP_ADD, 32'h7FC0_0000, 3'b000, 4'b1000);
        add_row(32'h3F80_0000, 32'hFF80_0001, FP_SUB, 32'h7FC0_0000, 3'b000, 4'b1000);
        // Largest finite doubled, exponent stays at 254
        add_row(32'h7F7F_FFFF, 32'h7F7F_FFFF, FP_ADD, 32'h7F7F_FFFF, 3'b000, 4'b0100);
        // 1.0 + 2^-30 leaves only sticky, 1.0 + 2^-24 sets guard
        add_row(32'h3F80_0000, 32'h3080_0000, FP_ADD, 32'h3F80_0000, 3'b001, 4'b0001);
        add_row(32'h3F80_0000, 32'h3380_0000, FP_ADD, 32'h3F80_0000, 3'b100, 4'b0001);
    endtask

    // ------------------------------------------------------------------------
    // Reset and idle checks
    // ------------------------------------------------------------------------

    task automatic check_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            #5;
            check_value("data_valid_o", out_valid, 32'h0);
            cycles++;
            if (cycles > 20) begin
                report_failure("reset was never released");
            end
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #5;
            check_value("data_valid_o", out_valid, 32'h0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stream driver and result collector
    // ------------------------------------------------------------------------

    task automatic present_row(input int idx, input bit stall);
        if (stall) begin
            rng_state = xorshift32(rng_state);
            // Enable is high on roughly three edges out of four
            clk_en = rng_state[0] | rng_state[3];
        end else begin
            clk_en = 1'b1;
        end
        if (idx < table_q.size()) begin
            addend_a  = table_q[idx].a;
            addend_b  = table_q[idx].b;
            operation = table_q[idx].op;
            in_valid  = 1'b1;
        end else begin
            in_valid = 1'b0;
        end
    endtask

    task automatic drive_table(input bit stall);
        int          idx;
        int          cycles;
        logic        took;
        int unsigned stamp;
        idx    = 0;
        cycles = 0;
        @(posedge clk);
        #1;
        present_row(idx, stall);
        while (idx < table_q.size()) begin
            @(posedge clk);
            // Read before the edge counter has counted this edge
            took  = clk_en && in_valid;
            stamp = en_edges;
            #1;
            // The row was sampled on this edge, note the enabled edges before it
            if (took) begin
                taken_q.push_back(stamp);
                idx++;
            end
            cycles++;
            if (cycles > 1000) begin
                report_failure("driver could not hand all rows to the DUT");
            end
            present_row(idx, stall);
        end
        clk_en = 1'b1;
    endtask

    task automatic collect_results();
        int      idle;
        logic    en;
        vector_t v;
        for (int k = 0; k < table_q.size(); k++) begin
            idle = 0;
            do begin
                @(posedge clk);
                en = clk_en;
                #5;
                idle++;
                if (idle > 200) begin
                    report_failure($sformatf("no result for row %0d within 200 cycles", k));
                end
            end while (!(en && out_valid));
            // A frozen output during a stall is not a new result
            if (taken_q.size() == 0) begin
                report_failure("result appeared without a matching input");
            end
            v = table_q[k];
            check_value("latency", en_edges - taken_q.pop_front(), 32'd4);
            check_value("result_o", result, v.result);
            check_value("round_bits_o", round_bits, v.rb);
            check_value("invalid_operation_o", invalid_op, v.flags[3]);
            check_value("overflow_o", overflow, v.flags[2]);
            check_value("underflow_o", underflow, v.flags[1]);
            check_value("inexact_o", inexact, v.flags[0]);
        end
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        clk_en    = 1'b1;
        in_valid  = 1'b0;
        addend_a  = '0;
        addend_b  = '0;
        operation = FP_ADD;
        load_table();

        check_reset();
        expect_idle(3);

        // Back-to-back rows with the enable held high
        fork
            drive_table(1'b0);
            collect_results();
        join
        expect_idle(3);

        // Same rows again under random stalls
        fork
            drive_table(1'b1);
            collect_results();
        join
        expect_idle(3);

        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fp_adder_props.sv ====
/*
 * Bound assertions for the pipelined float adder
 * Checks the four-edge valid latency against a model shift register, the
 * reset state of the output strobe and the consistency of the flags.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_adder_props (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    clk_en_i,
    input logic                    data_valid_i,
    input logic                    data_valid_o,
    input logic                    invalid_operation_o,
    input logic                    inexact_o,
    input logic                    overflow_o,
    input logic                    underflow_o,
    input fp_add_pkg::round_bits_t round_bits_o
);
    import fp_add_pkg::*;

    // Input strobe of the last four enabled edges, oldest in bit 3
    logic [3:0] valid_hist;

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            valid_hist <= {valid_hist[2:0], data_valid_i};
        end
        if (!rst_n_i) begin
            valid_hist <= '0;
        end
    end

    valid_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o == valid_hist[3])
        else $error("data_valid_o does not follow data_valid_i by four enabled edges");

    // The strobe is cleared by reset even while the clock enable is low
    valid_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !data_valid_o)
        else $error("data_valid_o still high one edge after reset");

    inexact_is_or: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        data_valid_o |-> (inexact_o == |round_bits_o))
        else $error("inexact_o differs from the OR of round_bits_o");

    // An invalid operation carries no datapath flags and no round bits
    invalid_alone: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (data_valid_o && invalid_operation_o) |->
            (!overflow_o && !underflow_o && (round_bits_o == '0)))
        else $error("invalid operation reported together with other flags");

endmodule

bind fp_adder fp_adder_props u_fp_adder_props (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .clk_en_i            (clk_en_i),
    .data_valid_i        (data_valid_i),
    .data_valid_o        (data_valid_o),
    .invalid_operation_o (invalid_operation_o),
    .inexact_o           (inexact_o),
    .overflow_o          (overflow_o),
    .underflow_o         (underflow_o),
    .round_bits_o        (round_bits_o)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
/*
 * Testbench clock and reset generator
 * Free-running 100 ns clock. Reset is held low over the first five rising
 * edges and released just after the fifth one.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    localparam int HALF_PERIOD_NS = 50;
    localparam int RESET_CYCLES   = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

    // Release lands 1 ns after an edge, like all other stimulus
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== fp_adder.sv ====
/*
 * Pipelined single-precision adder and subtractor
 * Four registered stages: unpack, align, sum, normalize. A new operand
 * pair is accepted on every enabled cycle and the result leaves four
 * enabled edges later, together with its flags and round bits.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_adder (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clk_en_i,
    input  logic                    data_valid_i,
    input  fp_add_pkg::float32_t    addend_a_i,
    input  fp_add_pkg::float32_t    addend_b_i,
    input  fp_add_pkg::fp_op_e      operation_i,
    output fp_add_pkg::float32_t    result_o,
    output logic                    data_valid_o,
    output logic                    invalid_operation_o,
    output logic                    inexact_o,
    output logic                    overflow_o,
    output logic                    underflow_o,
    output fp_add_pkg::round_bits_t round_bits_o
);
    import fp_add_pkg::*;

    unpack_stage_t unpack_s;
    align_stage_t  align_s;
    sum_stage_t    sum_s;
    norm_stage_t   norm_s;

    // ------------------------------------------------------------------------
    // Stage chain
    // ------------------------------------------------------------------------

    fp_add_unpack u_unpack (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en_i),
        .data_valid_i (data_valid_i),
        .addend_a_i   (addend_a_i),
        .addend_b_i   (addend_b_i),
        .operation_i  (operation_i),
        .stage_o      (unpack_s)
    );

    fp_add_align u_align (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .stage_i  (unpack_s),
        .stage_o  (align_s)
    );

    fp_add_sum u_sum (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .stage_i  (align_s),
        .stage_o  (sum_s)
    );

    fp_add_normalize u_normalize (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .clk_en_i (clk_en_i),
        .stage_i  (sum_s),
        .stage_o  (norm_s)
    );

    // Last stage register drives the ports directly
    assign result_o            = norm_s.result;
    assign data_valid_o        = norm_s.valid;
    assign invalid_operation_o = norm_s.invalid;
    assign overflow_o          = norm_s.overflow;
    assign underflow_o         = norm_s.underflow;
    assign round_bits_o        = norm_s.round_bits;
    // Any bit lost below the LSB makes the result inexact
    assign inexact_o           = |norm_s.round_bits;

endmodule

`default_nettype wire

// ==== fp_add_normalize.sv ====
/*
 * Adder stage 3, normalization
 * Brings the sum back into the hidden-bit form, either by one right shift
 * after a carry or by a left shift over the leading zeros. Raises overflow
 * and underflow, forms guard, round and sticky, and puts the canonical NaN
 * on an invalid operation.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_normalize (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    clk_en_i,
    input  fp_add_pkg::sum_stage_t  stage_i,
    output fp_add_pkg::norm_stage_t stage_o
);
    import fp_add_pkg::*;

    // Priority count from the MSB; an all-zero word gives its full width
    function automatic logic [LZ_W-1:0] count_lz(input logic [2*SIG_W-1:0] value);
        logic [LZ_W-1:0] count;
        count = LZ_W'(2 * SIG_W);
        for (int i = 0; i < 2 * SIG_W; i++) begin
            if (value[i]) begin
                count = LZ_W'(2 * SIG_W - 1 - i);
            end
        end
        return count;
    endfunction

    exp_t               exp_eff;
    logic [2*SIG_W-1:0] full_sig;
    logic [LZ_W-1:0]    lz;
    exp_t               lz_ext;
    logic               is_zero;
    logic [2*SIG_W-1:0] left_shifted;
    norm_stage_t        stage_d;

    assign exp_eff  = (stage_i.exponent == '0) ? EXP_MIN : stage_i.exponent;
    assign full_sig = {stage_i.magnitude, stage_i.shifted_out};
    assign lz       = count_lz(full_sig);
    assign lz_ext   = exp_t'(lz);
    assign is_zero  = (full_sig == '0);

    // ------------------------------------------------------------------------
    // Normalization and flags
    // ------------------------------------------------------------------------

    always_comb begin
        stage_d.valid           = stage_i.valid;
        stage_d.invalid         = stage_i.invalid;
        stage_d.overflow        = 1'b0;
        stage_d.underflow       = 1'b0;
        stage_d.result.sign     = stage_i.sign;
        stage_d.result.exponent = exp_eff;
        stage_d.result.fraction = stage_i.magnitude[MANT_W-1:0];
        left_shifted            = full_sig;

        if (stage_i.carry) begin
            // Carry out of the add, one step right and one up in exponent
            stage_d.result.fraction = stage_i.magnitude[MANT_W:1];
            if (exp_eff >= EXP_MAX - exp_t'(1)) begin
                // The next exponent would be infinity, keep the current one
                stage_d.overflow = 1'b1;
            end else begin
                stage_d.result.exponent = exp_eff + exp_t'(1);
            end
        end else if (is_zero) begin
            // Full cancellation is the bottom of the EXP_MIN rule
            stage_d.result.exponent = '0;
            stage_d.result.fraction = '0;
            stage_d.underflow       = 1'b1;
        end else if (lz_ext >= exp_eff) begin
            // Shift only as far as EXP_MIN allows, the hidden bit stays clear
            // and the field takes the subnormal encoding
            left_shifted            = full_sig << (exp_eff - EXP_MIN);
            stage_d.result.exponent = '0;
            stage_d.result.fraction = left_shifted[2*SIG_W-2:SIG_W];
            stage_d.underflow       = 1'b1;
        end else begin
            // Normal case, lz is zero when the hidden bit is already set
            left_shifted            = full_sig << lz;
            stage_d.result.exponent = exp_eff - lz_ext;
            stage_d.result.fraction = left_shifted[2*SIG_W-2:SIG_W];
        end

        // Round bits sit right below the LSB of the normalized fraction
        if (stage_i.carry) begin
            stage_d.round_bits = {stage_i.magnitude[0], stage_i.shifted_out[SIG_W-1],
                                  |stage_i.shifted_out[SIG_W-2:0]};
        end else begin
            stage_d.round_bits = {left_shifted[SIG_W-1], left_shifted[SIG_W-2],
                                  |left_shifted[SIG_W-3:0]};
        end

        // Invalid overrides everything, the flags of the datapath are void
        if (stage_i.invalid) begin
            stage_d.result     = CANONICAL_NAN;
            stage_d.round_bits = '0;
            stage_d.overflow   = 1'b0;
            stage_d.underflow  = 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fp_add_sum.sv ====
/*
 * Adder stage 2, significand sum
 * Adds or subtracts the aligned minor from the major significand. The
 * major is never the smaller one, so a subtraction already yields the
 * magnitude and the major sign is the result sign.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_sum (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     clk_en_i,
    input  fp_add_pkg::align_stage_t stage_i,
    output fp_add_pkg::sum_stage_t   stage_o
);
    import fp_add_pkg::*;

    sig_t             major_sig;
    logic             same_sign;
    logic [2*SIG_W:0] major_wide;
    logic [2*SIG_W:0] minor_wide;
    logic [2*SIG_W:0] total;
    sum_stage_t       stage_d;

    assign major_sig = {stage_i.major.exponent != '0, stage_i.major.fraction};
    assign same_sign = (stage_i.major.sign == stage_i.minor_sign);

    // ------------------------------------------------------------------------
    // Wide sum including the shifted-out bits
    // ------------------------------------------------------------------------

    // Top bit takes the carry, the low half keeps the exact fraction tail
    assign major_wide = {1'b0, major_sig, {SIG_W{1'b0}}};
    assign minor_wide = {1'b0, stage_i.minor_sig, stage_i.shifted_out};

    // The low half of the difference takes the borrow into account
    assign total = same_sign ? (major_wide + minor_wide) : (major_wide - minor_wide);

    always_comb begin
        stage_d.valid       = stage_i.valid;
        stage_d.invalid     = stage_i.invalid;
        stage_d.exponent    = stage_i.major.exponent;
        stage_d.magnitude   = total[2*SIG_W-1:SIG_W];
        stage_d.shifted_out = total[SIG_W-1:0];
        // A subtraction never carries, the top bit is only meaningful for adds
        stage_d.carry       = same_sign && total[2*SIG_W];

        // Exact cancellation gives +0 whatever the operand signs were
        if (!same_sign && (total == '0)) begin
            stage_d.sign = 1'b0;
        end else begin
            stage_d.sign = stage_i.major.sign;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fp_add_align.sv ====
/*
 * Adder stage 1, significand alignment
 * Shifts the minor significand right by the exponent distance so both
 * operands carry the same weight, keeping every bit that falls off.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_align (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      clk_en_i,
    input  fp_add_pkg::unpack_stage_t stage_i,
    output fp_add_pkg::align_stage_t  stage_o
);
    import fp_add_pkg::*;

    logic [2*SIG_W-1:0] minor_ext;
    logic [2*SIG_W-1:0] minor_shifted;
    align_stage_t       stage_d;

    // Lower half catches the bits shifted below the major LSB
    assign minor_ext = {stage_i.minor_sig, {SIG_W{1'b0}}};

    // Past the limit the whole significand has left the window
    assign minor_shifted = (stage_i.exp_diff >= SHIFT_OUT_LIMIT) ? '0 :
                           (minor_ext >> stage_i.exp_diff);

    always_comb begin
        stage_d.valid       = stage_i.valid;
        stage_d.invalid     = stage_i.invalid;
        stage_d.major       = stage_i.major;
        stage_d.minor_sign  = stage_i.minor_sign;
        stage_d.minor_sig   = minor_shifted[2*SIG_W-1:SIG_W];
        stage_d.shifted_out = minor_shifted[SIG_W-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fp_add_unpack.sv ====
/*
 * Adder stage 0, operand unpack
 * Applies the operation to the sign of B, detects the invalid cases and
 * orders the operands into major and minor by magnitude. Registers the
 * major operand, the minor significand and the exponent distance.
 */
`timescale 1ns/1ps
`default_nettype none

module fp_add_unpack (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      clk_en_i,
    input  logic                      data_valid_i,
    input  fp_add_pkg::float32_t      addend_a_i,
    input  fp_add_pkg::float32_t      addend_b_i,
    input  fp_add_pkg::fp_op_e        operation_i,
    output fp_add_pkg::unpack_stage_t stage_o
);
    import fp_add_pkg::*;

    float32_t      op_b;
    logic          a_is_nan;
    logic          b_is_nan;
    logic          a_is_inf;
    logic          b_is_inf;
    exp_t          a_exp_eff;
    exp_t          b_exp_eff;
    sig_t          a_sig;
    sig_t          b_sig;
    logic          a_is_major;
    unpack_stage_t stage_d;

    // B with its effective sign, so the rest of the pipe only ever adds
    assign op_b = {addend_b_i.sign ^ (operation_i == FP_SUB), addend_b_i.exponent,
                   addend_b_i.fraction};

    // ------------------------------------------------------------------------
    // Classification
    // ------------------------------------------------------------------------

    assign a_is_nan = (addend_a_i.exponent == EXP_MAX) && (addend_a_i.fraction != '0);
    assign b_is_nan = (op_b.exponent == EXP_MAX) && (op_b.fraction != '0);
    assign a_is_inf = (addend_a_i.exponent == EXP_MAX) && (addend_a_i.fraction == '0);
    assign b_is_inf = (op_b.exponent == EXP_MAX) && (op_b.fraction == '0);

    // Hidden bit is present only for a non-zero exponent
    assign a_sig = {addend_a_i.exponent != '0, addend_a_i.fraction};
    assign b_sig = {op_b.exponent != '0, op_b.fraction};

    // A subnormal has the same weight as exponent 1
    assign a_exp_eff = (addend_a_i.exponent == '0) ? EXP_MIN : addend_a_i.exponent;
    assign b_exp_eff = (op_b.exponent == '0) ? EXP_MIN : op_b.exponent;

    // Full significands decide on a tie, so a subnormal never beats a normal
    assign a_is_major = (a_exp_eff > b_exp_eff) ||
                        ((a_exp_eff == b_exp_eff) && (a_sig >= b_sig));

    // ------------------------------------------------------------------------
    // Swap and register
    // ------------------------------------------------------------------------

    always_comb begin
        stage_d.valid   = data_valid_i;
        // Any NaN, or infinities that cancel each other
        stage_d.invalid = a_is_nan || b_is_nan ||
                          (a_is_inf && b_is_inf && (addend_a_i.sign != op_b.sign));

        // Both effective exponents lie in 1..255, so the distance fits exp_t
        if (a_is_major) begin
            stage_d.major      = addend_a_i;
            stage_d.minor_sign = op_b.sign;
            stage_d.minor_sig  = b_sig;
            stage_d.exp_diff   = a_exp_eff - b_exp_eff;
        end else begin
            stage_d.major      = op_b;
            stage_d.minor_sign = addend_a_i.sign;
            stage_d.minor_sig  = a_sig;
            stage_d.exp_diff   = b_exp_eff - a_exp_eff;
        end

        // An infinite major absorbs the minor so the sum stays infinite
        if (a_is_inf || b_is_inf) begin
            stage_d.minor_sig = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            stage_o <= stage_d;
        end
        // Only the valid bit is cleared, the payload just follows it
        if (!rst_n_i) begin
            stage_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== fp_add_pkg.sv ====
/*
 * Single-precision adder package
 * Holds the float32 field types, the operation select, the round bits and
 * the structs that carry each pipeline stage into the next one. The format
 * constants used by every stage live here too.
 */
`default_nettype none

package fp_add_pkg;

    // ------------------------------------------------------------------------
    // Format widths and field types
    // ------------------------------------------------------------------------

    localparam int unsigned EXP_W  = 8;
    localparam int unsigned MANT_W = 23;
    // Significand with the hidden bit in front of the stored fraction
    localparam int unsigned SIG_W  = MANT_W + 1;
    // Leading-zero count over the significand plus the shifted-out bits
    localparam int unsigned LZ_W   = $clog2(2 * SIG_W + 1);

    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [MANT_W-1:0] mant_t;
    typedef logic [SIG_W-1:0]  sig_t;

    typedef struct packed {
        logic  sign;
        exp_t  exponent;
        mant_t fraction;
    } float32_t;

    // Subtraction is an addition with the sign of operand B flipped
    typedef enum logic {
        FP_ADD = 1'b0,
        FP_SUB = 1'b1
    } fp_op_e;

    // Bits below the result LSB, handed on to a later rounder
    typedef struct packed {
        logic guard;
        logic round;
        logic sticky;
    } round_bits_t;

    // ------------------------------------------------------------------------
    // Format constants
    // ------------------------------------------------------------------------

    localparam exp_t EXP_MAX = '1;
    localparam exp_t EXP_MIN = exp_t'(1);
    // Beyond this distance nothing of the minor operand is left
    localparam int unsigned SHIFT_OUT_LIMIT = 2 * SIG_W;
    // Quiet NaN with only the fraction MSB set
    localparam float32_t CANONICAL_NAN = '{
        sign:     1'b0,
        exponent: '1,
        fraction: {1'b1, {(MANT_W - 1){1'b0}}}
    };

    // ------------------------------------------------------------------------
    // Stage structs, each carrying its own valid bit
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic     valid;
        logic     invalid;
        float32_t major;
        logic     minor_sign;
        sig_t     minor_sig;
        exp_t     exp_diff;
    } unpack_stage_t;

    typedef struct packed {
        logic     valid;
        logic     invalid;
        float32_t major;
        logic     minor_sign;
        sig_t     minor_sig;
        sig_t     shifted_out;
    } align_stage_t;

    typedef struct packed {
        logic valid;
        logic invalid;
        logic sign;
        exp_t exponent;
        sig_t magnitude;
        logic carry;
        sig_t shifted_out;
    } sum_stage_t;

    typedef struct packed {
        logic        valid;
        float32_t    result;
        round_bits_t round_bits;
        logic        invalid;
        logic        overflow;
        logic        underflow;
    } norm_stage_t;

endpackage

`default_nettype wire
